// File: ex_pkg.sv
// Shared width, operation encodings and types for the execute stage, imported by each design file
package ex_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Default datapath width, passed down from the top level
  localparam int XLEN       = 32;
  // Register file has 32 entries
  localparam int REG_ADDR_W = 5;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////
  // Operation encodings
  //////////////////////////////

  // Functional unit select from decode
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MD  = 1'b1
  } unit_e;

  // Single-cycle ALU operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9
  } alu_op_e;

  // Multiply function on the left of each name, divide function on the right
  typedef enum logic [1:0] {
    MD_MUL_DIV    = 2'b00,
    MD_MULH_DIVU  = 2'b01,
    MD_MULHSU_REM = 2'b10,
    MD_MULHU_REMU = 2'b11
  } md_fn_e;

  // Multiply/divide view of the operation word
  typedef struct packed {
    logic   is_div;
    logic   spare;
    md_fn_e fn;
  } md_op_t;

  // One operation word, read as ALU or MD op depending on unit_e
  typedef union packed {
    alu_op_e alu;
    md_op_t  md;
  } ex_op_u;

endpackage

// File: md_unit_if.sv
// Issue and result handshake between the execute stage and one multicycle unit
`timescale 1ns/1ps

interface md_unit_if #(
  parameter int DATA_W = 32
);
  import ex_pkg::*;

  // Issue side
  logic              start;
  logic              busy_n;
  md_fn_e            fn;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;

  // Result side, result valid while done is high
  logic [DATA_W-1:0] result;
  logic              done;
  logic              ack;

  // Execute stage view
  modport stage (
    output start, fn, op_a, op_b, ack,
    input  busy_n, result, done
  );

  // Multiplier or divider view
  modport unit (
    input  start, fn, op_a, op_b, ack,
    output busy_n, result, done
  );

endinterface

// File: ex_alu.sv
// Combinational integer ALU of the execute stage, instantiated once by ex_stage
`timescale 1ns/1ps

module ex_alu #(
  parameter int DATA_W = 32
) (
  input  ex_pkg::alu_op_e   operator_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  output logic [DATA_W-1:0] result_o
);
  import ex_pkg::*;

  // Shift amount taken from the low bits of operand b
  localparam int SHAMT_W = $clog2(DATA_W);

  logic [SHAMT_W-1:0] shamt;
  logic [DATA_W-1:0]  sum;
  logic [DATA_W-1:0]  diff;
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt = operand_b_i[SHAMT_W-1:0];

  //////////////////////////////
  // Adder and comparators
  //////////////////////////////

  assign sum         = operand_a_i + operand_b_i;
  assign diff        = operand_a_i - operand_b_i;
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    unique case (operator_i)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      // Logical shifts fill with zeros
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Compare results land in bit 0
      ALU_SLT:  result_o = {{(DATA_W-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(DATA_W-1){1'b0}}, lt_unsigned};
      // Unused encodings give zero
      default:  result_o = '0;
    endcase
  end

endmodule

// File: ex_mult.sv
// Two-cycle multiplier for MUL, MULH, MULHSU and MULHU, driven by ex_stage over md_unit_if
`timescale 1ns/1ps

module ex_mult #(
  parameter int DATA_W = 32
) (
  input logic     clk,
  input logic     rst_n,
  md_unit_if.unit md_o
);
  import ex_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_DONE
  } mult_state_e;

  mult_state_e              state_q;
  logic                     latch;
  logic                     a_signed;
  logic                     b_signed;
  md_fn_e                   fn_q;
  // Operands carry one extra bit so one signed multiply covers all variants
  logic signed [DATA_W:0]   a_q;
  logic signed [DATA_W:0]   b_q;
  logic signed [2*DATA_W+1:0] prod_full;
  logic [2*DATA_W-1:0]      prod_q;

  assign latch = md_o.start && md_o.busy_n;

  // MULH treats both as signed, MULHSU only a, MULHU neither
  assign a_signed = (md_o.fn == MD_MUL_DIV) || (md_o.fn == MD_MULH_DIVU)
                 || (md_o.fn == MD_MULHSU_REM);
  assign b_signed = (md_o.fn == MD_MUL_DIV) || (md_o.fn == MD_MULH_DIVU);

  assign prod_full = a_q * b_q;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      unique case (state_q)
        ST_IDLE: if (latch) state_q <= ST_BUSY;
        // Abort when the stage drops start
        ST_BUSY: state_q <= md_o.start ? ST_DONE : ST_IDLE;
        ST_DONE: if (md_o.ack || !md_o.start) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Operand capture and product register
  always_ff @(posedge clk) begin
    if (latch) begin
      fn_q <= md_o.fn;
      a_q  <= {a_signed & md_o.op_a[DATA_W-1], md_o.op_a};
      b_q  <= {b_signed & md_o.op_b[DATA_W-1], md_o.op_b};
    end
    if (state_q == ST_BUSY) begin
      prod_q <= prod_full[2*DATA_W-1:0];
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign md_o.busy_n = (state_q == ST_IDLE);
  assign md_o.done   = (state_q == ST_DONE);
  // Low word for MUL, high word for the three high variants
  assign md_o.result = (fn_q == MD_MUL_DIV) ? prod_q[DATA_W-1:0] : prod_q[2*DATA_W-1:DATA_W];

endmodule

// File: ex_div.sv
// Iterative restoring divider for DIV, DIVU, REM and REMU, driven by ex_stage over md_unit_if
`timescale 1ns/1ps

module ex_div #(
  parameter int DATA_W = 32
) (
  input logic     clk,
  input logic     rst_n,
  md_unit_if.unit md_o
);
  import ex_pkg::*;

  localparam int CNT_W = $clog2(DATA_W);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } div_state_e;

  div_state_e        state_q;
  logic              latch;
  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic              b_zero;
  logic              overflow;
  logic [DATA_W-1:0] abs_a;
  logic [DATA_W-1:0] abs_b;
  md_fn_e            fn_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [DATA_W-1:0] quot_q;
  logic [DATA_W-1:0] rem_q;
  logic [DATA_W-1:0] divisor_q;
  logic              neg_q_q;
  logic              neg_r_q;
  logic [DATA_W:0]   shifted;
  logic [DATA_W:0]   trial;
  logic [DATA_W-1:0] quot_res;
  logic [DATA_W-1:0] rem_res;

  assign latch = md_o.start && md_o.busy_n;

  //////////////////////////////
  // Setup decode
  //////////////////////////////

  // DIV and REM are the signed functions
  assign is_signed = (md_o.fn == MD_MUL_DIV) || (md_o.fn == MD_MULHSU_REM);
  assign a_neg     = is_signed && md_o.op_a[DATA_W-1];
  assign b_neg     = is_signed && md_o.op_b[DATA_W-1];
  assign abs_a     = a_neg ? -md_o.op_a : md_o.op_a;
  assign abs_b     = b_neg ? -md_o.op_b : md_o.op_b;
  assign b_zero    = (md_o.op_b == '0);
  // Most negative value divided by minus one
  assign overflow  = is_signed && (md_o.op_a == {1'b1, {(DATA_W-1){1'b0}}})
                  && (md_o.op_b == '1);

  // One restoring step, next dividend bit shifted into the partial remainder
  assign shifted = {rem_q, quot_q[DATA_W-1]};
  assign trial   = shifted - {1'b0, divisor_q};

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      unique case (state_q)
        // Special cases finish right after setup
        ST_IDLE: begin
          if (latch) state_q <= (b_zero || overflow) ? ST_DONE : ST_RUN;
        end
        ST_RUN: begin
          if (!md_o.start) state_q <= ST_IDLE;
          else if (cnt_q == CNT_W'(DATA_W-1)) state_q <= ST_DONE;
        end
        ST_DONE: if (md_o.ack || !md_o.start) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    if (latch) begin
      fn_q  <= md_o.fn;
      cnt_q <= '0;
      if (b_zero) begin
        // Quotient all ones, remainder is the dividend
        quot_q  <= '1;
        rem_q   <= md_o.op_a;
        neg_q_q <= 1'b0;
        neg_r_q <= 1'b0;
      end else if (overflow) begin
        quot_q  <= md_o.op_a;
        rem_q   <= '0;
        neg_q_q <= 1'b0;
        neg_r_q <= 1'b0;
      end else begin
        quot_q    <= abs_a;
        rem_q     <= '0;
        divisor_q <= abs_b;
        neg_q_q   <= a_neg ^ b_neg;
        // Remainder takes the sign of the dividend
        neg_r_q   <= a_neg;
      end
    end else if (state_q == ST_RUN) begin
      cnt_q <= cnt_q + 1'b1;
      if (!trial[DATA_W]) begin
        rem_q  <= trial[DATA_W-1:0];
        quot_q <= {quot_q[DATA_W-2:0], 1'b1};
      end else begin
        rem_q  <= shifted[DATA_W-1:0];
        quot_q <= {quot_q[DATA_W-2:0], 1'b0};
      end
    end
  end

  //////////////////////////////
  // Sign fix and outputs
  //////////////////////////////

  assign quot_res = neg_q_q ? -quot_q : quot_q;
  assign rem_res  = neg_r_q ? -rem_q : rem_q;

  assign md_o.busy_n = (state_q == ST_IDLE);
  assign md_o.done   = (state_q == ST_DONE);
  assign md_o.result = ((fn_q == MD_MULHSU_REM) || (fn_q == MD_MULHU_REMU)) ? rem_res : quot_res;

endmodule

// File: ex_stage.sv
// Execute stage top level with ALU, multiplier, divider and the EX/WB pipeline register
`timescale 1ns/1ps

module ex_stage #(
  parameter int DATA_W = ex_pkg::XLEN
) (
  input  logic              clk,
  input  logic              rst_n,
  // Instruction from decode
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  ex_pkg::unit_e     unit_sel_i,
  input  ex_pkg::ex_op_u    op_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  input  ex_pkg::reg_addr_t rd_addr_i,
  input  logic              rf_we_i,
  // Pipeline controller
  input  logic              kill_i,
  input  logic              halt_i,
  // Writeback side
  input  logic              wb_ready_i,
  output logic              wb_valid_o,
  output logic              wb_rf_we_o,
  output ex_pkg::reg_addr_t wb_rd_addr_o,
  output logic [DATA_W-1:0] wb_wdata_o
);
  import ex_pkg::*;

  logic              instr_valid;
  logic              sel_md;
  logic              sel_div;
  logic              unit_done;
  logic              ex_valid;
  logic [DATA_W-1:0] alu_result;
  logic [DATA_W-1:0] ex_result;

  md_unit_if #(.DATA_W(DATA_W)) mul_if ();
  md_unit_if #(.DATA_W(DATA_W)) div_if ();

  //////////////////////////////
  // Kill/halt gating
  //////////////////////////////

  // Kill and halt both hide the instruction from the units
  assign instr_valid = in_valid_i && !kill_i && !halt_i;
  assign sel_md      = (unit_sel_i == UNIT_MD);
  assign sel_div     = op_i.md.is_div;

  //////////////////////////////
  // Unit dispatch
  //////////////////////////////

  // Start is a level, held until the result leaves EX
  assign mul_if.start = instr_valid && sel_md && !sel_div;
  assign mul_if.fn    = op_i.md.fn;
  assign mul_if.op_a  = operand_a_i;
  assign mul_if.op_b  = operand_b_i;
  assign mul_if.ack   = wb_ready_i;

  assign div_if.start = instr_valid && sel_md && sel_div;
  assign div_if.fn    = op_i.md.fn;
  assign div_if.op_a  = operand_a_i;
  assign div_if.op_b  = operand_b_i;
  assign div_if.ack   = wb_ready_i;

  ex_alu #(.DATA_W(DATA_W)) i_ex_alu (
    .operator_i  (op_i.alu),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (alu_result)
  );

  ex_mult #(.DATA_W(DATA_W)) i_ex_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .md_o  (mul_if.unit)
  );

  ex_div #(.DATA_W(DATA_W)) i_ex_div (
    .clk   (clk),
    .rst_n (rst_n),
    .md_o  (div_if.unit)
  );

  // ALU is always finished, MD waits for the selected unit
  assign unit_done = sel_md ? (sel_div ? div_if.done : mul_if.done) : 1'b1;
  assign ex_valid  = instr_valid && unit_done;

  // Killed instruction leaves EX at once
  assign in_ready_o = kill_i || (!halt_i && wb_ready_i && unit_done);

  //////////////////////////////
  // Result mux
  //////////////////////////////

  always_comb begin
    unique case ({sel_md, sel_div})
      2'b10:   ex_result = mul_if.result;
      2'b11:   ex_result = div_if.result;
      default: ex_result = alu_result;
    endcase
  end

  //////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////

  // Valid and write enable track bubbles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o <= 1'b0;
      wb_rf_we_o <= 1'b0;
    end else if (wb_ready_i) begin
      wb_valid_o <= ex_valid;
      wb_rf_we_o <= ex_valid && rf_we_i;
    end
  end

  // Address and data only move with a finished instruction
  always_ff @(posedge clk) begin
    if (wb_ready_i && ex_valid) begin
      wb_rd_addr_o <= rd_addr_i;
      wb_wdata_o   <= ex_result;
    end
  end

endmodule

// File: ex_stage_checker.sv
// Concurrent assertions on the execute stage handshakes, bound into ex_stage for simulation
`timescale 1ns/1ps

module ex_stage_checker #(
  parameter int DATA_W = 32
) (
  input logic              clk,
  input logic              rst_n,
  input logic              in_ready_o,
  input logic              kill_i,
  input logic              halt_i,
  input logic              wb_ready_i,
  input logic              wb_valid_o,
  input logic              wb_rf_we_o,
  input ex_pkg::reg_addr_t wb_rd_addr_o,
  input logic [DATA_W-1:0] wb_wdata_o
);

  // Number of failed assertions
  int assert_fails = 0;

  // Stalled writeback keeps its payload
  a_wb_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wb_valid_o && !wb_ready_i) |=> ($stable(wb_valid_o) && $stable(wb_rf_we_o)
      && $stable(wb_rd_addr_o) && $stable(wb_wdata_o))
  ) else begin
    assert_fails++;
    $error("wb outputs changed during a writeback stall");
  end

  a_wb_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(wb_valid_o)
  ) else begin
    assert_fails++;
    $error("wb_valid_o is unknown");
  end

  // Halt freezes EX unless a kill drops the instruction
  a_halt_blocks: assert property (
    @(posedge clk) disable iff (!rst_n) (halt_i && !kill_i) |-> !in_ready_o
  ) else begin
    assert_fails++;
    $error("in_ready_o high during halt");
  end

endmodule

bind ex_stage ex_stage_checker #(.DATA_W(DATA_W)) i_checker (.*);

// File: tb_ex_stage.sv
// Testbench for the execute stage that checks random instructions against a model in a scoreboard
`timescale 1ns/1ps

module tb_ex_stage;
  import ex_pkg::*;

  localparam int DATA_W  = XLEN;
  localparam int SH_W    = $clog2(DATA_W);
  localparam int N_ALU   = 60;
  localparam int N_MUL   = 40;
  localparam int N_DIV   = 40;
  localparam int N_MIX   = 80;
  localparam int N_CTL   = 60;
  localparam int N_WE    = 20;
  // Six directed divides plus the random ones
  localparam int N_INSTR = N_ALU + N_MUL + N_DIV + 6 + N_MIX + N_CTL + N_WE;
  localparam int TIMEOUT = N_INSTR * (DATA_W + 4) + 1000;
  localparam logic [DATA_W-1:0] INT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  logic              clk;
  logic              rst_n;
  logic              in_valid_i;
  logic              in_ready_o;
  unit_e             unit_sel_i;
  ex_op_u            op_i;
  logic [DATA_W-1:0] operand_a_i;
  logic [DATA_W-1:0] operand_b_i;
  reg_addr_t         rd_addr_i;
  logic              rf_we_i;
  logic              kill_i;
  logic              halt_i;
  logic              wb_ready_i;
  logic              wb_valid_o;
  logic              wb_rf_we_o;
  reg_addr_t         wb_rd_addr_o;
  logic [DATA_W-1:0] wb_wdata_o;

  integer seed;
  int     errors;
  int     checks;
  int     wb_count;
  int     cycles;
  logic   wb_rand;
  logic   ctl_rand;
  logic   expect_wb;
  // Scoreboard entries are {rd_addr, rf_we, data}
  logic [REG_ADDR_W+DATA_W:0] exp_q[$];

  ex_stage #(.DATA_W(DATA_W)) i_ex_stage (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [DATA_W-1:0] model(input logic md, input logic [3:0] op,
                                              input logic [DATA_W-1:0] a, b);
    logic signed [DATA_W-1:0] sa;
    logic signed [DATA_W-1:0] sb;
    logic [2*DATA_W-1:0]      ea;
    logic [2*DATA_W-1:0]      eb;
    logic [2*DATA_W-1:0]      prod;
    sa = a;
    sb = b;
    // a is signed except for MULHU and b only for MUL and MULH
    ea = {{DATA_W{a[DATA_W-1] && (op[1:0] != 2'b11)}}, a};
    eb = {{DATA_W{b[DATA_W-1] && !op[1]}}, b};
    prod = ea * eb;
    if (!md) begin
      case (op)
        4'h0:    model = a + b;
        4'h1:    model = a - b;
        4'h2:    model = a & b;
        4'h3:    model = a | b;
        4'h4:    model = a ^ b;
        4'h5:    model = a << b[SH_W-1:0];
        4'h6:    model = a >> b[SH_W-1:0];
        4'h7:    model = sa >>> b[SH_W-1:0];
        4'h8:    model = {{(DATA_W-1){1'b0}}, sa < sb};
        4'h9:    model = {{(DATA_W-1){1'b0}}, a < b};
        default: model = '0;
      endcase
    end else if (!op[3]) begin
      model = (op[1:0] == 2'b00) ? prod[DATA_W-1:0] : prod[2*DATA_W-1:DATA_W];
    end else if (b == '0) begin
      // op[1] selects the remainder on a zero divisor
      model = op[1] ? a : '1;
    end else if (!op[0] && (a == INT_MIN) && (b == '1)) begin
      model = op[1] ? '0 : a;
    end else begin
      case (op[1:0])
        2'b00:   model = sa / sb;
        2'b01:   model = a / b;
        2'b10:   model = sa % sb;
        default: model = a % b;
      endcase
    end
  endfunction

  function automatic int rand_below(input int n);
    rand_below = {$random(seed)} % n;
  endfunction

  // Edge values show up often
  function automatic logic [DATA_W-1:0] pick_operand();
    case (rand_below(8))
      0:       pick_operand = '0;
      1:       pick_operand = INT_MIN;
      2:       pick_operand = '1;
      3:       pick_operand = ~INT_MIN;
      4:       pick_operand = 1;
      default: pick_operand = $random(seed);
    endcase
  endfunction

  task automatic check(input string name, input logic [DATA_W-1:0] exp, act);
    checks++;
    if (exp !== act) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // Scoreboard
  //////////////////////////////

  // Runs mid-cycle while inputs and outputs hold until the next rising edge
  task automatic sample();
    logic [REG_ADDR_W+DATA_W:0] exp;
    if (expect_wb) check("wb_valid_o", 1, wb_valid_o);
    expect_wb = 1'b0;
    if (wb_valid_o && wb_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected writeback to x%0d at %0t with nothing in flight",
                 wb_rd_addr_o, $time);
        errors++;
      end else begin
        exp = exp_q.pop_front();
        wb_count++;
        check("wb_rd_addr_o", exp[REG_ADDR_W+DATA_W:DATA_W+1], wb_rd_addr_o);
        check("wb_rf_we_o", exp[DATA_W], wb_rf_we_o);
        check("wb_wdata_o", exp[DATA_W-1:0], wb_wdata_o);
      end
    end
    // Killed transfers leave nothing behind
    if (in_valid_i && in_ready_o && !kill_i) begin
      exp_q.push_back({rd_addr_i, rf_we_i,
                       model(unit_sel_i == UNIT_MD, op_i, operand_a_i, operand_b_i)});
      expect_wb = 1'b1;
    end
  endtask

  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (rst_n) sample();
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Holds one instruction until it is taken under random stalls, kill and halt
  task automatic issue(input logic md, input logic [3:0] op, input logic [DATA_W-1:0] a, b,
                       input reg_addr_t rd, input logic we);
    int   t;
    int   kill_at;
    int   halt_at;
    logic taken;
    t = 0;
    kill_at = -1;
    halt_at = -1;
    taken = 1'b0;
    if (ctl_rand) begin
      case (rand_below(4))
        0:       kill_at = rand_below(DATA_W + 2);
        1:       halt_at = rand_below(DATA_W + 2);
        default: ;
      endcase
    end
    while (!taken) begin
      @(negedge clk);
      in_valid_i  = 1'b1;
      unit_sel_i  = unit_e'(md);
      op_i        = op;
      operand_a_i = a;
      operand_b_i = b;
      rd_addr_i   = rd;
      rf_we_i     = we;
      kill_i      = (t == kill_at);
      // Three-cycle halt pulse
      halt_i      = (halt_at >= 0) && (t >= halt_at) && (t < halt_at + 3);
      wb_ready_i  = wb_rand ? (rand_below(4) != 0) : 1'b1;
      #1;
      // Kill always frees EX, an ALU op needs only a free writeback
      if (kill_i || (!md && !halt_i && wb_ready_i)) begin
        check("in_ready_o", 1, in_ready_o);
      end else if (halt_i || !wb_ready_i) begin
        check("in_ready_o", 0, in_ready_o);
      end
      taken = in_ready_o;
      t++;
    end
  endtask

  task automatic drain();
    @(negedge clk);
    in_valid_i = 1'b0;
    kill_i     = 1'b0;
    halt_i     = 1'b0;
    wb_ready_i = 1'b1;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  // kind 0 ALU, 1 multiply, 2 divide, 3 any
  // we_sel 2 means random write enable
  task automatic run_random(input int kind, input int count, input int we_sel);
    int         i;
    int         k;
    logic [3:0] op;
    logic       we;
    for (i = 0; i < count; i++) begin
      k = (kind == 3) ? rand_below(3) : kind;
      case (k)
        0:       op = 4'(rand_below(10));
        1:       op = {2'b00, 2'(rand_below(4))};
        default: op = {2'b10, 2'(rand_below(4))};
      endcase
      we = (we_sel == 2) ? 1'(rand_below(2)) : 1'(we_sel);
      issue(k != 0, op, pick_operand(), pick_operand(), reg_addr_t'(rand_below(32)), we);
    end
    drain();
  endtask

  task automatic report_test(input string name);
    $display("Test %-10s finished: %0d writebacks, %0d errors so far", name, wb_count, errors);
  endtask

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the pipeline stopped making progress", TIMEOUT);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int i;
    seed        = 32'haa20_23e2;
    in_valid_i  = 1'b0;
    unit_sel_i  = UNIT_ALU;
    op_i        = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    rd_addr_i   = '0;
    rf_we_i     = 1'b0;
    kill_i      = 1'b0;
    halt_i      = 1'b0;
    wb_ready_i  = 1'b1;
    wb_rand     = 1'b0;
    ctl_rand    = 1'b0;
    expect_wb   = 1'b0;
    errors      = 0;
    checks      = 0;
    wb_count    = 0;
    rst_n       = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check("wb_valid_o", 0, wb_valid_o);
    check("wb_rf_we_o", 0, wb_rf_we_o);
    report_test("reset");
    run_random(0, N_ALU, 1);
    report_test("alu");
    run_random(1, N_MUL, 1);
    report_test("mul");
    // Overflow of DIV and REM followed by each function with a zero divisor
    issue(1'b1, 4'b1000, INT_MIN, '1, 5'd1, 1'b1);
    issue(1'b1, 4'b1010, INT_MIN, '1, 5'd2, 1'b1);
    for (i = 0; i < 4; i++) begin
      issue(1'b1, {2'b10, 2'(i)}, $random(seed), '0, reg_addr_t'(i + 3), 1'b1);
    end
    run_random(2, N_DIV, 1);
    report_test("div");
    wb_rand = 1'b1;
    run_random(3, N_MIX, 2);
    wb_rand = 1'b0;
    report_test("mixed");
    ctl_rand = 1'b1;
    run_random(3, N_CTL, 1);
    ctl_rand = 1'b0;
    report_test("kill_halt");
    run_random(3, N_WE, 0);
    report_test("no_write");
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             i_ex_stage.i_checker.assert_fails);
    if (errors == 0 && i_ex_stage.i_checker.assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
ex_pkg.sv
md_unit_if.sv
ex_alu.sv
ex_mult.sv
ex_div.sv
ex_stage.sv
ex_stage_checker.sv
tb_ex_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
